/* cart/cart_chip_detect.sv */
//==========================================================================
// Coprocessor classification from the captured header
// Produces the ROM type byte: chip code on top, mapping below
//==========================================================================

`timescale 1ns/1ns

module cart_chip_detect (
	input  logic                clk_sys,
	input  logic                reset,
	input  snes_pkg::ioctl_t    ioctl,
	input  snes_pkg::cart_cfg_t cfg,
	input  snes_pkg::cart_hdr_t hdr,
	output logic [7:0]          rom_type
);

	logic       wr_d;
	logic       dl_start;
	logic       chip_hit;
	logic [3:0] chip_code;

	// First download write of a new image
	assign dl_start = ioctl.download & (ioctl.wr ^ wr_d) & (ioctl.addr == '0);

	// Rules in priority order
	always_comb begin
		chip_hit  = 1'b1;
		chip_code = rom_type[7:4];
		if (hdr.mapper == 8'h30 && hdr.cart_type == 8'h05 && hdr.company == 8'hB2) begin
			chip_code = snes_pkg::CHIP_DSP3;
		end else if (((hdr.mapper == 8'h20 || hdr.mapper == 8'h21) && hdr.cart_type == 8'h03) ||
			(hdr.mapper == 8'h30 && hdr.cart_type == 8'h05) ||
			(hdr.mapper == 8'h31 && (hdr.cart_type == 8'h03 || hdr.cart_type == 8'h05))) begin
			chip_code = snes_pkg::CHIP_DSP1;
		end else if (hdr.mapper == 8'h20 && hdr.cart_type == 8'h05) begin
			chip_code = snes_pkg::CHIP_DSP2;
		end else if (hdr.mapper == 8'h30 && hdr.cart_type == 8'h03) begin
			chip_code = snes_pkg::CHIP_DSP4;
		end else begin
			chip_hit = 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_d     <= 1'b0;
			rom_type <= 8'h00;
		end else begin
			wr_d <= ioctl.wr;
			if (dl_start) begin
				rom_type <= {6'd0, cfg.mapping};
			end else if (!ioctl.download) begin
				rom_type[1:0] <= cfg.mapping;
				if (chip_hit) begin
					rom_type[7:4] <= chip_code;
				end
			end
		end
	end

endmodule

/* cart/cart_header_snoop.sv */
//==========================================================================
// Cartridge header capture during download
// Mapper, type, size and company fields plus ROM and RAM address masks
//==========================================================================

`timescale 1ns/1ns

module cart_header_snoop (
	input  logic                clk_sys,
	input  logic                reset,
	input  snes_pkg::ioctl_t    ioctl,
	input  snes_pkg::cart_cfg_t cfg,
	output snes_pkg::cart_hdr_t hdr,
	output logic [23:0]         rom_mask,
	output logic [23:0]         ram_mask
);

	logic                          wr_d;
	logic                          dl_write;
	logic [snes_pkg::IOCTL_AW-1:0] hdr_prefix;
	logic [3:0]                    rom_shift;

	// Header bank depends on the selected mapping
	always_comb begin
		case (cfg.mapping)
			snes_pkg::MAP_HIROM:   hdr_prefix = snes_pkg::HDR_PREFIX_HI;
			snes_pkg::MAP_EXHIROM: hdr_prefix = snes_pkg::HDR_PREFIX_EXHI;
			default:               hdr_prefix = snes_pkg::HDR_PREFIX_LO;
		endcase
	end

	assign dl_write  = ioctl.download & (ioctl.wr ^ wr_d);
	// Sizes below 7 are bogus headers, assume 4 MB
	assign rom_shift = (hdr.rom_size < 4'd7) ? 4'd12 : hdr.rom_size;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_d     <= 1'b0;
			hdr      <= '0;
			rom_mask <= '0;
			ram_mask <= '0;
		end else begin
			wr_d <= ioctl.wr;
			if (dl_write) begin
				if (ioctl.addr == '0) begin
					hdr.ram_size <= 4'h0;
				end
				if (ioctl.addr == (hdr_prefix | snes_pkg::HDR_MAPPER_OFS)) begin
					hdr.mapper <= ioctl.dout[15:8];
				end
				if (ioctl.addr == (hdr_prefix | snes_pkg::HDR_TYPE_OFS)) begin
					hdr.cart_type <= ioctl.dout[7:0];
					hdr.rom_size  <= ioctl.dout[11:8];
				end
				if (ioctl.addr == (hdr_prefix | snes_pkg::HDR_RAMSZ_OFS)) begin
					hdr.ram_size <= ioctl.dout[3:0];
				end
				if (ioctl.addr == (hdr_prefix | snes_pkg::HDR_COMPANY_OFS)) begin
					hdr.company <= ioctl.dout[7:0];
				end

				// Masks lag the fields by one write
				rom_mask <= (24'd1024 << rom_shift) - 24'd1;
				if (hdr.ram_size == 4'h0) begin
					ram_mask <= 24'd0;
				end else begin
					ram_mask <= (24'd1024 << hdr.ram_size) - 24'd1;
				end
			end
		end
	end

endmodule

/* common/snes_pkg.sv */
//==========================================================================
// Shared definitions for the console memory glue
// Memory widths, cartridge header offsets, bank prefixes, chip codes
// and the structs passed between the blocks
//==========================================================================

package snes_pkg;

	// Address widths from the console memory map
	localparam int ROM_AW   = 23;
	localparam int WRAM_AW  = 17;
	localparam int ARAM_AW  = 16;
	localparam int BSRAM_AW = 20;
	localparam int IOCTL_AW = 25;

	// Header byte offsets within the header bank
	localparam logic [IOCTL_AW-1:0] HDR_MAPPER_OFS  = 25'h0007FD4;
	localparam logic [IOCTL_AW-1:0] HDR_TYPE_OFS    = 25'h0007FD6;
	localparam logic [IOCTL_AW-1:0] HDR_RAMSZ_OFS   = 25'h0007FD8;
	localparam logic [IOCTL_AW-1:0] HDR_COMPANY_OFS = 25'h0007FDA;

	// Bank prefix per mapping, ORed onto the offsets
	localparam logic [IOCTL_AW-1:0] HDR_PREFIX_LO   = 25'h0000000;
	localparam logic [IOCTL_AW-1:0] HDR_PREFIX_HI   = 25'h0008000;
	localparam logic [IOCTL_AW-1:0] HDR_PREFIX_EXHI = 25'h0408000;

	// Coprocessor codes, upper nibble of rom_type
	localparam logic [3:0] CHIP_DSP1 = 4'h8;
	localparam logic [3:0] CHIP_DSP2 = 4'h9;
	localparam logic [3:0] CHIP_DSP3 = 4'hA;
	localparam logic [3:0] CHIP_DSP4 = 4'hB;

	typedef enum logic [1:0] {
		MAP_LOROM   = 2'd0,
		MAP_HIROM   = 2'd1,
		MAP_EXHIROM = 2'd2
	} rom_map_e;

	// Download port from the host
	typedef struct packed {
		logic                wr;
		logic [IOCTL_AW-1:0] addr;
		logic [15:0]         dout;
		logic                download;
	} ioctl_t;

	typedef struct packed {
		rom_map_e mapping;
		logic     pal;
		logic     blend;
	} cart_cfg_t;

	// Captured cartridge header fields
	typedef struct packed {
		logic [7:0] mapper;
		logic [7:0] cart_type;
		logic [3:0] rom_size;
		logic [3:0] ram_size;
		logic [7:0] company;
	} cart_hdr_t;

	typedef struct packed {
		logic [23:0] addr;
		logic        ce;
		logic        word;
	} rom_cpu_t;

	typedef struct packed {
		logic [ROM_AW-1:0] addr;
		logic [15:0]       din;
		logic              we;
		logic              req;
	} rom_mem_t;

	// RAM payloads, one per tracker
	typedef struct packed {
		logic [WRAM_AW-1:0] addr;
		logic [7:0]         data;
	} wram_pl_t;

	typedef struct packed {
		logic [ARAM_AW-1:0] addr;
		logic [7:0]         data;
	} aram_pl_t;

	typedef struct packed {
		logic [BSRAM_AW-1:0] addr;
		logic [7:0]          data;
	} bsram_pl_t;

endpackage

/* files.f */
common/snes_pkg.sv
hdl/snes_config_regs.sv
cart/cart_header_snoop.sv
cart/cart_chip_detect.sv
mem/mem_req_tracker.sv
mem/rom_req_port.sv
hdl/snes_glue_top.sv
tests/snes_glue_assertions.sv
tests/tb_snes_glue.sv

/* hdl/snes_config_regs.sv */
//==========================================================================
// Status word decode into the registered cartridge configuration
//==========================================================================

`timescale 1ns/1ns

module snes_config_regs (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic [31:0]         status,
	input  logic                download,
	output snes_pkg::cart_cfg_t cfg
);

	// Host menu bits
	logic [1:0] map_sel;
	logic       region_pal;
	logic       blend_off;

	assign map_sel    = status[2:1];
	assign region_pal = status[14];
	assign blend_off  = status[16];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg.mapping <= snes_pkg::MAP_LOROM;
			cfg.pal     <= 1'b0;
			cfg.blend   <= 1'b1;
		end else begin
			cfg.mapping <= snes_pkg::rom_map_e'(map_sel);
			cfg.blend   <= ~blend_off;
			// Region only changes between downloads
			if (!download) begin
				cfg.pal <= region_pal;
			end
		end
	end

endmodule

/* hdl/snes_glue_top.sv */
//==========================================================================
// Glue top level between the console core and the SDRAM controller
// Configuration registers, cartridge header logic, ROM port and
// the work, audio and backup RAM request trackers
//==========================================================================

`timescale 1ns/1ns

module snes_glue_top (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [31:0]          status,
	input  snes_pkg::ioctl_t     ioctl,
	input  snes_pkg::rom_cpu_t   rom_cpu,
	input  logic [15:0]          rom_dout,
	input  snes_pkg::wram_pl_t   wram_pl_in,
	input  logic                 wram_rd,
	input  logic                 wram_wr,
	input  snes_pkg::aram_pl_t   aram_pl_in,
	input  logic                 aram_rd,
	input  logic                 aram_wr,
	input  snes_pkg::bsram_pl_t  bsram_pl_in,
	input  logic                 bsram_rd,
	input  logic                 bsram_wr,
	output snes_pkg::cart_cfg_t  cfg,
	output logic [7:0]           rom_type,
	output logic [23:0]          rom_mask,
	output logic [23:0]          ram_mask,
	output snes_pkg::rom_mem_t   rom_mem,
	output logic [15:0]          rom_q,
	output snes_pkg::wram_pl_t   wram_pl_out,
	output logic                 wram_req,
	output logic                 wram_we,
	output snes_pkg::aram_pl_t   aram_pl_out,
	output logic                 aram_req,
	output logic                 aram_we,
	output snes_pkg::bsram_pl_t  bsram_pl_out,
	output logic                 bsram_req,
	output logic                 bsram_we
);

	snes_pkg::cart_hdr_t hdr;

	//==========================================================================
	// Cartridge configuration and header
	//==========================================================================

	snes_config_regs i_config_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.status   (status),
		.download (ioctl.download),
		.cfg      (cfg)
	);

	cart_header_snoop i_header_snoop (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.cfg      (cfg),
		.hdr      (hdr),
		.rom_mask (rom_mask),
		.ram_mask (ram_mask)
	);

	cart_chip_detect i_chip_detect (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.cfg      (cfg),
		.hdr      (hdr),
		.rom_type (rom_type)
	);

	//==========================================================================
	// Memory request ports
	//==========================================================================

	rom_req_port i_rom_port (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.rom_cpu  (rom_cpu),
		.rom_dout (rom_dout),
		.rom_mem  (rom_mem),
		.rom_q    (rom_q)
	);

	mem_req_tracker #(.payload_t(snes_pkg::wram_pl_t)) i_wram_tracker (
		.clk_sys (clk_sys),
		.reset   (reset),
		.rd      (wram_rd),
		.wr      (wram_wr),
		.pl_in   (wram_pl_in),
		.pl_out  (wram_pl_out),
		.req     (wram_req),
		.we      (wram_we)
	);

	mem_req_tracker #(.payload_t(snes_pkg::aram_pl_t)) i_aram_tracker (
		.clk_sys (clk_sys),
		.reset   (reset),
		.rd      (aram_rd),
		.wr      (aram_wr),
		.pl_in   (aram_pl_in),
		.pl_out  (aram_pl_out),
		.req     (aram_req),
		.we      (aram_we)
	);

	mem_req_tracker #(.payload_t(snes_pkg::bsram_pl_t)) i_bsram_tracker (
		.clk_sys (clk_sys),
		.reset   (reset),
		.rd      (bsram_rd),
		.wr      (bsram_wr),
		.pl_in   (bsram_pl_in),
		.pl_out  (bsram_pl_out),
		.req     (bsram_req),
		.we      (bsram_we)
	);

endmodule

/* mem/mem_req_tracker.sv */
//==========================================================================
// RAM request tracker
// Turns CPU read and write levels into a toggle request with a
// captured payload and a write flag
//==========================================================================

`timescale 1ns/1ns

module mem_req_tracker #(
	parameter type payload_t = snes_pkg::wram_pl_t
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     rd,
	input  logic     wr,
	input  payload_t pl_in,
	output payload_t pl_out,
	output logic     req,
	output logic     we
);

	logic rd_d;
	logic trigger;

	// we doubles as the delayed write level
	assign trigger = (rd & ~rd_d) | (wr & ~we) |
		((rd | wr) & (pl_in.addr != pl_out.addr));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_d <= 1'b0;
			we   <= 1'b0;
			req  <= 1'b0;
		end else begin
			rd_d <= rd;
			we   <= wr;
			if (trigger) begin
				req <= ~req;
			end
		end
	end

	// Address starts at all ones so the first access always fires
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pl_out.addr <= '1;
		end else if (trigger) begin
			pl_out.addr <= pl_in.addr;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (trigger) begin
			pl_out.data <= pl_in.data;
		end
	end

endmodule

/* mem/rom_req_port.sv */
//==========================================================================
// ROM port requests for download writes and CPU reads
// Read data byte swap for odd single-byte accesses
//==========================================================================

`timescale 1ns/1ns

module rom_req_port (
	input  logic               clk_sys,
	input  logic               reset,
	input  snes_pkg::ioctl_t   ioctl,
	input  snes_pkg::rom_cpu_t rom_cpu,
	input  logic [15:0]        rom_dout,
	output snes_pkg::rom_mem_t rom_mem,
	output logic [15:0]        rom_q
);

	logic                        wr_d;
	logic                        dl_write;
	logic                        cpu_new;
	logic [snes_pkg::ROM_AW-1:0] cpu_word_addr;

	assign cpu_word_addr = rom_cpu.addr[23:1];
	assign dl_write      = ioctl.download & (ioctl.wr ^ wr_d);
	assign cpu_new       = ~ioctl.download & rom_cpu.ce & (cpu_word_addr != rom_mem.addr);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_d        <= 1'b0;
			rom_mem.req <= 1'b0;
			rom_mem.we  <= 1'b0;
			rom_mem.addr <= '1;
		end else begin
			wr_d       <= ioctl.wr;
			rom_mem.we <= ioctl.download;
			if (dl_write) begin
				rom_mem.req  <= ~rom_mem.req;
				rom_mem.addr <= ioctl.addr[23:1];
			end else if (cpu_new) begin
				rom_mem.req  <= ~rom_mem.req;
				rom_mem.addr <= cpu_word_addr;
			end
		end
	end

	// Write data only matters during a download
	always_ff @(posedge clk_sys) begin
		if (dl_write) begin
			rom_mem.din <= ioctl.dout;
		end
	end

	// Odd byte reads want the high byte on the low lane
	assign rom_q = (rom_cpu.word || !rom_cpu.addr[0]) ? rom_dout :
		{rom_dout[7:0], rom_dout[15:8]};

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the glue testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_snes_glue \
	-Mdir "$BUILD_DIR" -o tb_snes_glue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/tb_snes_glue" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG_FILE"; then
	exit 1
fi
exit 0

/* tests/snes_glue_assertions.sv */
//==========================================================================
// Concurrent checks on the glue top level
// Tracker request toggles, ROM mask shape and ROM write enable
//==========================================================================

`timescale 1ns/1ns

module snes_glue_assertions (
	input logic        clk_sys,
	input logic        reset,
	input logic        download,
	input logic        rom_we,
	input logic [23:0] rom_mask,
	input logic        wram_req,
	input logic        wram_rd,
	input logic        wram_wr,
	input logic        wram_addr_new,
	input logic        aram_req,
	input logic        aram_rd,
	input logic        aram_wr,
	input logic        aram_addr_new,
	input logic        bsram_req,
	input logic        bsram_rd,
	input logic        bsram_wr,
	input logic        bsram_addr_new
);

	// Trigger is a rising rd or wr, or an access to a new address
	// A toggle shows up exactly one cycle after its trigger
	wram_toggle: assert property (@(posedge clk_sys) disable iff (reset)
		(wram_req != $past(wram_req)) ==
		(($past(wram_rd) && !$past(wram_rd, 2)) ||
		($past(wram_wr) && !$past(wram_wr, 2)) ||
		$past((wram_rd || wram_wr) && wram_addr_new)))
		else $error("wram req toggle does not match a trigger one cycle earlier");

	aram_toggle: assert property (@(posedge clk_sys) disable iff (reset)
		(aram_req != $past(aram_req)) ==
		(($past(aram_rd) && !$past(aram_rd, 2)) ||
		($past(aram_wr) && !$past(aram_wr, 2)) ||
		$past((aram_rd || aram_wr) && aram_addr_new)))
		else $error("aram req toggle does not match a trigger one cycle earlier");

	bsram_toggle: assert property (@(posedge clk_sys) disable iff (reset)
		(bsram_req != $past(bsram_req)) ==
		(($past(bsram_rd) && !$past(bsram_rd, 2)) ||
		($past(bsram_wr) && !$past(bsram_wr, 2)) ||
		$past((bsram_rd || bsram_wr) && bsram_addr_new)))
		else $error("bsram req toggle does not match a trigger one cycle earlier");

	// Mask is all ones below some bit
	rom_mask_shape: assert property (@(posedge clk_sys) disable iff (reset)
		((rom_mask + 24'd1) & rom_mask) == 24'd0)
		else $error("rom_mask is not one less than a power of two");

	rom_we_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		rom_we |-> $past(download))
		else $error("rom_mem.we high outside a download");

endmodule

bind snes_glue_top snes_glue_assertions i_glue_assertions (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.download       (ioctl.download),
	.rom_we         (rom_mem.we),
	.rom_mask       (rom_mask),
	.wram_req       (wram_req),
	.wram_rd        (wram_rd),
	.wram_wr        (wram_wr),
	.wram_addr_new  (wram_pl_in.addr != wram_pl_out.addr),
	.aram_req       (aram_req),
	.aram_rd        (aram_rd),
	.aram_wr        (aram_wr),
	.aram_addr_new  (aram_pl_in.addr != aram_pl_out.addr),
	.bsram_req      (bsram_req),
	.bsram_rd       (bsram_rd),
	.bsram_wr       (bsram_wr),
	.bsram_addr_new (bsram_pl_in.addr != bsram_pl_out.addr)
);

/* tests/tb_snes_glue.sv */
//==========================================================================
// Testbench for the console memory glue
// Clock, reset, directed tests for header snooping, chip detection,
// the ROM port, the RAM trackers and the configuration registers
//==========================================================================

`timescale 1ns/1ns

module tb_snes_glue;

	// About twenty times the length of the directed sequence
	localparam int TIMEOUT_CYCLES = 2000;

	logic                 clk_sys;
	logic                 reset;
	logic [31:0]          status;
	snes_pkg::ioctl_t     ioctl;
	snes_pkg::rom_cpu_t   rom_cpu;
	logic [15:0]          rom_dout;
	snes_pkg::wram_pl_t   wram_pl_in;
	logic                 wram_rd;
	logic                 wram_wr;
	snes_pkg::aram_pl_t   aram_pl_in;
	logic                 aram_rd;
	logic                 aram_wr;
	snes_pkg::bsram_pl_t  bsram_pl_in;
	logic                 bsram_rd;
	logic                 bsram_wr;
	snes_pkg::cart_cfg_t  cfg;
	logic [7:0]           rom_type;
	logic [23:0]          rom_mask;
	logic [23:0]          ram_mask;
	snes_pkg::rom_mem_t   rom_mem;
	logic [15:0]          rom_q;
	snes_pkg::wram_pl_t   wram_pl_out;
	logic                 wram_req;
	logic                 wram_we;
	snes_pkg::aram_pl_t   aram_pl_out;
	logic                 aram_req;
	logic                 aram_we;
	snes_pkg::bsram_pl_t  bsram_pl_out;
	logic                 bsram_req;
	logic                 bsram_we;

	integer seed;
	int     error_count;
	int     tests_run;
	int     tests_failed;
	int     cycle_count;

	snes_glue_top i_snes_glue_top (.*);

	always #2 clk_sys = ~clk_sys;

	//==========================================================================
	// Helpers
	//==========================================================================

	// Inputs change 1 ns after the rising edge
	task step();
		@(posedge clk_sys);
		#1;
	endtask

	task apply_reset();
		reset = 1'b1;
		repeat (10) step();
		reset = 1'b0;
	endtask

	task report_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		error_count = error_count + 1;
	endtask

	task finish_test(input string name, input int errors_before);
		tests_run = tests_run + 1;
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("%s: fail, %0d errors", name, error_count - errors_before);
		end
	endtask

	task set_mapping(input logic [1:0] mapping);
		status[2:1] = mapping;
		step();
		if (cfg.mapping !== mapping)
			report_mismatch("cfg.mapping", 32'(cfg.mapping), 32'(mapping));
		step();
	endtask

	// One download write, which must give exactly one ROM request
	task automatic dl_write(input logic [24:0] addr, input logic [15:0] data);
		logic req_before;
		req_before = rom_mem.req;
		ioctl.addr = addr;
		ioctl.dout = data;
		ioctl.wr   = ~ioctl.wr;
		step();
		if (rom_mem.req !== ~req_before)
			report_mismatch("rom_mem.req", 32'(rom_mem.req), 32'(~req_before));
		if (rom_mem.addr !== addr[23:1])
			report_mismatch("rom_mem.addr", 32'(rom_mem.addr), 32'(addr[23:1]));
		if (rom_mem.din !== data)
			report_mismatch("rom_mem.din", 32'(rom_mem.din), 32'(data));
		if (rom_mem.we !== 1'b1)
			report_mismatch("rom_mem.we", 32'(rom_mem.we), 32'h1);
		step();
		if (rom_mem.req !== ~req_before)
			report_mismatch("rom_mem.req", 32'(rom_mem.req), 32'(~req_before));
	endtask

	task end_download();
		ioctl.download = 1'b0;
		step();
		step();
	endtask

	task automatic check_masks(input logic [23:0] exp_rom, input logic [23:0] exp_ram);
		if (rom_mask !== exp_rom)
			report_mismatch("rom_mask", 32'(rom_mask), 32'(exp_rom));
		if (ram_mask !== exp_ram)
			report_mismatch("ram_mask", 32'(ram_mask), 32'(exp_ram));
	endtask

	//==========================================================================
	// Directed tests
	//==========================================================================

	task automatic test_lorom_header();
		int          errs;
		logic [31:0] rnd;
		errs = error_count;
		set_mapping(2'd0);
		ioctl.download = 1'b1;
		rnd = $random(seed);
		dl_write(25'h0000000, rnd[15:0]);
		dl_write(25'h0007FD4, {8'h20, rnd[23:16]});
		dl_write(25'h0007FD6, 16'h0A03);
		dl_write(25'h0007FD8, 16'h0003);
		// Masks need one more write after the header
		dl_write(25'h0008000, rnd[31:16]);
		end_download();
		check_masks(24'h0FFFFF, 24'h001FFF);
		if (rom_type !== 8'h80)
			report_mismatch("rom_type", 32'(rom_type), 32'h80);
		finish_test("lorom_header", errs);
	endtask

	task automatic test_hirom_exhirom();
		int          errs;
		logic [31:0] rnd;
		errs = error_count;
		apply_reset();
		set_mapping(2'd1);

		// LoROM offsets under HiROM mapping are ignored
		rnd = $random(seed);
		ioctl.download = 1'b1;
		dl_write(25'h0000000, rnd[15:0]);
		dl_write(25'h0007FD4, {8'h30, rnd[7:0]});
		dl_write(25'h0007FD6, 16'h0A05);
		dl_write(25'h0000010, rnd[31:16]);
		end_download();
		check_masks(24'h3FFFFF, 24'h000000);
		if (rom_type !== 8'h01)
			report_mismatch("rom_type", 32'(rom_type), 32'h01);

		rnd = $random(seed);
		ioctl.download = 1'b1;
		dl_write(25'h0000000, rnd[15:0]);
		dl_write(25'h000FFD4, {8'h20, rnd[7:0]});
		dl_write(25'h000FFD6, 16'h0B05);
		dl_write(25'h000FFD8, 16'h0001);
		dl_write(25'h0010000, rnd[31:16]);
		end_download();
		check_masks(24'h1FFFFF, 24'h0007FF);
		if (rom_type !== 8'h91)
			report_mismatch("rom_type", 32'(rom_type), 32'h91);

		set_mapping(2'd2);
		rnd = $random(seed);
		ioctl.download = 1'b1;
		dl_write(25'h0000000, rnd[15:0]);
		dl_write(25'h040FFD4, {8'h30, rnd[7:0]});
		dl_write(25'h040FFD6, 16'h0C03);
		dl_write(25'h0410000, rnd[31:16]);
		end_download();
		check_masks(24'h3FFFFF, 24'h000000);
		if (rom_type !== 8'hB2)
			report_mismatch("rom_type", 32'(rom_type), 32'hB2);
		finish_test("hirom_exhirom", errs);
	endtask

	task automatic test_wram_tracker();
		int          errs;
		logic [31:0] rnd;
		logic [16:0] addr_a;
		logic [16:0] addr_b;
		logic [16:0] addr_c;
		logic [7:0]  data_w;
		logic        req_before;
		errs = error_count;
		rnd = $random(seed);
		addr_a = rnd[16:0];
		addr_b = addr_a ^ 17'h00100;
		addr_c = addr_a ^ 17'h10001;

		req_before = wram_req;
		wram_pl_in.addr = addr_a;
		wram_rd = 1'b1;
		step();
		if (wram_req !== ~req_before)
			report_mismatch("wram_req", 32'(wram_req), 32'(~req_before));
		if (wram_pl_out.addr !== addr_a)
			report_mismatch("wram_pl_out.addr", 32'(wram_pl_out.addr), 32'(addr_a));

		// Held read at the same address stays quiet
		req_before = wram_req;
		repeat (3) step();
		if (wram_req !== req_before)
			report_mismatch("wram_req", 32'(wram_req), 32'(req_before));

		wram_pl_in.addr = addr_b;
		step();
		if (wram_req !== ~req_before)
			report_mismatch("wram_req", 32'(wram_req), 32'(~req_before));
		if (wram_pl_out.addr !== addr_b)
			report_mismatch("wram_pl_out.addr", 32'(wram_pl_out.addr), 32'(addr_b));
		req_before = wram_req;
		step();
		if (wram_req !== req_before)
			report_mismatch("wram_req", 32'(wram_req), 32'(req_before));

		wram_rd = 1'b0;
		step();
		rnd = $random(seed);
		data_w = rnd[7:0];
		req_before = wram_req;
		wram_pl_in.addr = addr_c;
		wram_pl_in.data = data_w;
		wram_wr = 1'b1;
		step();
		if (wram_req !== ~req_before)
			report_mismatch("wram_req", 32'(wram_req), 32'(~req_before));
		if (wram_we !== 1'b1)
			report_mismatch("wram_we", 32'(wram_we), 32'h1);
		if (wram_pl_out.addr !== addr_c)
			report_mismatch("wram_pl_out.addr", 32'(wram_pl_out.addr), 32'(addr_c));
		if (wram_pl_out.data !== data_w)
			report_mismatch("wram_pl_out.data", 32'(wram_pl_out.data), 32'(data_w));
		wram_wr = 1'b0;
		req_before = wram_req;
		step();
		if (wram_we !== 1'b0)
			report_mismatch("wram_we", 32'(wram_we), 32'h0);
		if (wram_req !== req_before)
			report_mismatch("wram_req", 32'(wram_req), 32'(req_before));
		finish_test("wram_tracker", errs);
	endtask

	task automatic test_rom_runtime();
		int          errs;
		logic [31:0] rnd;
		logic        req_before;
		errs = error_count;
		req_before = rom_mem.req;
		rom_cpu.addr = 24'h123457;
		rom_cpu.word = 1'b0;
		rom_cpu.ce = 1'b1;
		step();
		if (rom_mem.req !== ~req_before)
			report_mismatch("rom_mem.req", 32'(rom_mem.req), 32'(~req_before));
		if (rom_mem.addr !== 23'h091A2B)
			report_mismatch("rom_mem.addr", 32'(rom_mem.addr), 32'h091A2B);

		// Other byte of the same word
		req_before = rom_mem.req;
		rom_cpu.addr = 24'h123456;
		step();
		step();
		if (rom_mem.req !== req_before)
			report_mismatch("rom_mem.req", 32'(rom_mem.req), 32'(req_before));

		rnd = $random(seed);
		rom_dout = rnd[15:0];
		rom_cpu.addr = 24'h123457;
		step();
		if (rom_q !== {rom_dout[7:0], rom_dout[15:8]})
			report_mismatch("rom_q", 32'(rom_q), 32'({rom_dout[7:0], rom_dout[15:8]}));
		rom_cpu.word = 1'b1;
		step();
		if (rom_q !== rom_dout)
			report_mismatch("rom_q", 32'(rom_q), 32'(rom_dout));

		req_before = rom_mem.req;
		rom_cpu.addr = 24'h200000;
		step();
		if (rom_mem.req !== ~req_before)
			report_mismatch("rom_mem.req", 32'(rom_mem.req), 32'(~req_before));
		if (rom_mem.addr !== 23'h100000)
			report_mismatch("rom_mem.addr", 32'(rom_mem.addr), 32'h100000);
		rom_cpu.ce = 1'b0;
		step();
		finish_test("rom_runtime", errs);
	endtask

	task automatic test_config_and_rams();
		int          errs;
		logic [31:0] rnd;
		logic        aram_before;
		logic        bsram_before;
		errs = error_count;
		status[16] = 1'b1;
		status[14] = 1'b1;
		step();
		if (cfg.blend !== 1'b0)
			report_mismatch("cfg.blend", 32'(cfg.blend), 32'h0);
		if (cfg.pal !== 1'b1)
			report_mismatch("cfg.pal", 32'(cfg.pal), 32'h1);

		// Region holds while a download runs
		ioctl.download = 1'b1;
		status[14] = 1'b0;
		status[16] = 1'b0;
		step();
		step();
		if (cfg.pal !== 1'b1)
			report_mismatch("cfg.pal", 32'(cfg.pal), 32'h1);
		if (cfg.blend !== 1'b1)
			report_mismatch("cfg.blend", 32'(cfg.blend), 32'h1);
		ioctl.download = 1'b0;
		step();
		if (cfg.pal !== 1'b0)
			report_mismatch("cfg.pal", 32'(cfg.pal), 32'h0);

		rnd = $random(seed);
		aram_before = aram_req;
		bsram_before = bsram_req;
		aram_pl_in.addr = rnd[15:0];
		aram_pl_in.data = rnd[23:16];
		aram_wr = 1'b1;
		step();
		aram_wr = 1'b0;
		if (aram_req !== ~aram_before)
			report_mismatch("aram_req", 32'(aram_req), 32'(~aram_before));
		if (aram_pl_out.addr !== rnd[15:0])
			report_mismatch("aram_pl_out.addr", 32'(aram_pl_out.addr), 32'(rnd[15:0]));
		if (aram_pl_out.data !== rnd[23:16])
			report_mismatch("aram_pl_out.data", 32'(aram_pl_out.data), 32'(rnd[23:16]));
		if (aram_we !== 1'b1)
			report_mismatch("aram_we", 32'(aram_we), 32'h1);
		if (bsram_req !== bsram_before)
			report_mismatch("bsram_req", 32'(bsram_req), 32'(bsram_before));
		step();
		if (aram_req !== ~aram_before)
			report_mismatch("aram_req", 32'(aram_req), 32'(~aram_before));

		rnd = $random(seed);
		bsram_pl_in.addr = rnd[19:0];
		bsram_pl_in.data = rnd[31:24];
		bsram_wr = 1'b1;
		step();
		bsram_wr = 1'b0;
		if (bsram_req !== ~bsram_before)
			report_mismatch("bsram_req", 32'(bsram_req), 32'(~bsram_before));
		if (bsram_pl_out.addr !== rnd[19:0])
			report_mismatch("bsram_pl_out.addr", 32'(bsram_pl_out.addr), 32'(rnd[19:0]));
		if (bsram_pl_out.data !== rnd[31:24])
			report_mismatch("bsram_pl_out.data", 32'(bsram_pl_out.data), 32'(rnd[31:24]));
		if (bsram_we !== 1'b1)
			report_mismatch("bsram_we", 32'(bsram_we), 32'h1);
		step();
		if (bsram_req !== ~bsram_before)
			report_mismatch("bsram_req", 32'(bsram_req), 32'(~bsram_before));
		finish_test("config_and_rams", errs);
	endtask

	//==========================================================================
	// Run control
	//==========================================================================

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count = cycle_count + 1;
		end
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		seed = 70;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		clk_sys = 1'b0;
		reset = 1'b1;
		status = 32'h0;
		ioctl = '0;
		rom_cpu = '0;
		rom_dout = 16'h0;
		wram_pl_in = '0;
		wram_rd = 1'b0;
		wram_wr = 1'b0;
		aram_pl_in = '0;
		aram_rd = 1'b0;
		aram_wr = 1'b0;
		bsram_pl_in = '0;
		bsram_rd = 1'b0;
		bsram_wr = 1'b0;

		apply_reset();
		test_lorom_header();
		test_hirom_exhirom();
		test_wram_tracker();
		test_rom_runtime();
		test_config_and_rams();

		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule
